// File: include/sc_defs.svh
// Build-time constants for the smartcard interface.
// Queue depth, divider width and divider reset value.

`ifndef SC_DEFS_SVH
`define SC_DEFS_SVH

// ******************************
// Queue sizing
// ******************************

`define SC_FIFO_DEPTH 4 // Entries in each of the transmit and receive queues.

// ******************************
// Bit timing
// ******************************

`define SC_DIV_W 8 // Width of the host-programmable etu divider.

// One etu is divider+1 clocks, so 7 gives 8 clocks per bit.
`define SC_DIV_RESET 7

`endif

// File: hdl/sc_pkg.sv
// Shared types: Wishbone request and response, receive entry,
// register address map and the divider type.

`default_nettype none

`include "sc_defs.svh"

package sc_pkg;

  // ******************************
  // Host bus
  // ******************************

  typedef struct packed {
    logic       cyc; // Bus cycle in progress.
    logic       stb; // Strobe for this access.
    logic       we;  // 1 for write.
    logic [1:0] adr; // Register select, see regAddr_e.
    logic [7:0] dat; // Write data.
  } wbReq_t;

  typedef struct packed {
    logic       ack; // Registered acknowledge.
    logic [7:0] dat; // Read data, valid with ack.
  } wbRsp_t;

  // Register map.
  typedef enum logic [1:0] {
    DATA    = 2'd0, // Write pushes TX byte, read pops RX entry.
    STATUS  = 2'd1,
    DIVIDER = 2'd2
  } regAddr_e;

  // ******************************
  // Card side
  // ******************************

  typedef struct packed {
    logic [7:0] data;      // Received character.
    logic       parityErr; // Even parity check failed.
  } rxEntry_t;

  typedef logic [`SC_DIV_W-1:0] divider_t;

endpackage

`default_nettype wire

// File: hdl/sc_baud_gen.sv
// Bit-time generator for the transmit shifter.
// One-cycle tick every divider+1 clocks.

`default_nettype none

`include "sc_defs.svh"

module sc_baud_gen (
  input  logic              CLK_I,
  input  logic              RST_I,
  input  sc_pkg::divider_t  divider, // Clocks per etu minus one.
  input  logic              divLoad, // Divider was just rewritten.
  output logic              tick     // Pulses once per etu.
);

  // ******************************
  // Down-counter
  // ******************************

  logic [`SC_DIV_W-1:0] count; // Clocks left until the next tick.

  always_ff @(posedge CLK_I)
  begin
    if (RST_I || divLoad)
    begin
      // Restart the period so a new rate begins on a clean boundary.
      count <= divider;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= divider; // Reload for the next etu.
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sc_fifo.sv
// Synchronous queue with valid/ready on both sides.
// Payload type and depth are parameters.

`default_nettype none

module sc_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     CLK_I,
  input  logic     RST_I,
  input  payload_t pushData,
  input  logic     pushValid,
  output logic     pushReady,
  output payload_t popData,
  output logic     popValid,
  input  logic     popReady
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width.
  localparam int CW = $clog2(DEPTH + 1);               // Count width.

  payload_t        mem [DEPTH];
  logic [PW-1:0]   wrPtr;
  logic [PW-1:0]   rdPtr;
  logic [CW-1:0]   count; // Entries held.
  logic            doPush;
  logic            doPop;

  assign pushReady = (count != CW'(DEPTH)); // Room for one more.
  assign popValid  = (count != '0);
  assign popData   = mem[rdPtr];            // Head entry, no extra latency.

  assign doPush = pushValid && pushReady;
  assign doPop  = popValid && popReady;

  // ******************************
  // Pointers and occupancy
  // ******************************

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= (wrPtr == PW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // Wrap.
      if (doPop)
        rdPtr <= (rdPtr == PW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

  // Storage.
  always_ff @(posedge CLK_I)
  begin
    if (doPush)
      mem[wrPtr] <= pushData;
  end

endmodule

`default_nettype wire

// File: hdl/sc_out_shifter.sv
// Character serializer for the card IO line.
// Start, eight data bits LSB first, even parity, released guard.

`default_nettype none

module sc_out_shifter (
  input  logic       CLK_I,
  input  logic       RST_I,
  input  logic [7:0] txData,
  input  logic       txValid,
  output logic       txReady,
  input  logic       tick,    // One pulse per etu.
  output logic       scIo,    // 1 releases the line, 0 pulls it low.
  output logic       sending  // Frame in progress.
);

  // ******************************
  // State
  // ******************************

  logic [10:0] shiftReg; // Parity, data, start, released lead-in.
  logic [3:0]  bitCnt;   // Ticks left in the frame; 0 when idle.
  logic        acceptQ;  // A byte was taken last cycle.
  logic        idle;
  logic        accept;
  logic        parity;

  assign idle    = (bitCnt == '0);
  assign txReady = idle && !acceptQ; // One-cycle gap after each take.
  assign accept  = txValid && txReady;
  assign parity  = ^txData;          // Even parity over the byte.

  // Never drive the line between frames.
  assign scIo = idle ? 1'b1 : shiftReg[0];

  // ******************************
  // Control
  // ******************************

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      bitCnt  <= '0;
      sending <= 1'b0;
      acceptQ <= 1'b0;
    end
    else
    begin
      acceptQ <= accept;
      if (accept)
      begin
        bitCnt  <= 4'd12; // Lead-in, start, 8 data, parity, guard.
        sending <= 1'b1;
      end
      else if (!idle && tick)
      begin
        bitCnt <= bitCnt - 1'b1;
        if (bitCnt == 4'd1)
          sending <= 1'b0; // Last tick ends the frame.
      end
    end
  end

  // Frame shifter.
  always_ff @(posedge CLK_I)
  begin
    if (accept)
      shiftReg <= {parity, txData, 2'b01};
    else if (!idle && tick)
      shiftReg <= {1'b1, shiftReg[10:1]}; // Released bits fill behind.
  end

endmodule

`default_nettype wire

// File: hdl/sc_in_shifter.sv
// Character deserializer for the card IO line.
// Start detection, mid-bit sampling and parity check.

`default_nettype none

`include "sc_defs.svh"

module sc_in_shifter (
  input  logic             CLK_I,
  input  logic             RST_I,
  input  logic             scIo,     // Sensed line level, asynchronous.
  input  logic             enable,   // Low while our own frame is on the line.
  input  sc_pkg::divider_t divider,
  output sc_pkg::rxEntry_t rxEntry,
  output logic             rxValid   // One-cycle push strobe.
);

  typedef enum logic [1:0] {
    IDLE,
    START,
    BITS,
    STOP
  } state_e;

  // ******************************
  // Line synchronizer
  // ******************************

  logic sync1;
  logic sync2;
  logic lastLevel; // Previous synchronized level for edge detection.
  logic fallEdge;

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      sync1     <= 1'b1; // Line idles released.
      sync2     <= 1'b1;
      lastLevel <= 1'b1;
    end
    else
    begin
      sync1     <= scIo;
      sync2     <= sync1;
      lastLevel <= sync2;
    end
  end

  assign fallEdge = lastLevel && !sync2;

  // ******************************
  // Bit timing
  // ******************************

  logic [`SC_DIV_W:0]   etuHalf;  // Half an etu, rounded down.
  logic [`SC_DIV_W-1:0] halfLoad; // Counter load for the start sample.
  logic [`SC_DIV_W-1:0] etuCnt;
  logic [3:0]           bitIdx;   // Samples taken in BITS.
  logic [8:0]           rxShift;  // Parity in [8], data LSB in [0].
  state_e               state;

  assign etuHalf  = ({1'b0, divider} + 1'b1) >> 1;
  assign halfLoad = (etuHalf == '0) ? '0 : `SC_DIV_W'(etuHalf - 1'b1);

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      state   <= IDLE;
      etuCnt  <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end
    else
    begin
      rxValid <= 1'b0;
      if (!enable)
        state <= IDLE; // Ignore the echo of our own transmission.
      else
      begin
        case (state)
          IDLE:
          begin
            if (fallEdge)
            begin
              etuCnt <= halfLoad; // Aim at the middle of the start bit.
              state  <= START;
            end
          end
          START:
          begin
            if (etuCnt != '0)
              etuCnt <= etuCnt - 1'b1;
            else if (!sync2)
            begin
              etuCnt <= divider; // Start confirmed.
              bitIdx <= '0;
              state  <= BITS;
            end
            else
              state <= IDLE; // Glitch.
          end
          BITS:
          begin
            if (etuCnt != '0)
              etuCnt <= etuCnt - 1'b1;
            else
            begin
              etuCnt <= divider;
              bitIdx <= bitIdx + 1'b1;
              if (bitIdx == 4'd8)
                state <= STOP; // Parity was the last sample.
            end
          end
          STOP:
          begin
            if (etuCnt != '0)
              etuCnt <= etuCnt - 1'b1;
            else
            begin
              rxValid <= 1'b1; // Push one etu after parity.
              state   <= IDLE;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Sample register, LSB first.
  always_ff @(posedge CLK_I)
  begin
    if (enable && state == BITS && etuCnt == '0)
      rxShift <= {sync2, rxShift[8:1]};
  end

  // Stable from the push until the next start sample.
  assign rxEntry.data      = rxShift[7:0];
  assign rxEntry.parityErr = ^rxShift; // Nonzero means odd count of ones.

endmodule

`default_nettype wire

// File: hdl/sc_wb_regs.sv
// Wishbone slave register block: DATA, STATUS and DIVIDER.

`default_nettype none

`include "sc_defs.svh"

module sc_wb_regs (
  input  logic             CLK_I,
  input  logic             RST_I,
  input  sc_pkg::wbReq_t   wbReq,
  output sc_pkg::wbRsp_t   wbRsp,
  output logic [7:0]       txPushData,
  output logic             txPushValid,
  input  logic             txPushReady,
  input  sc_pkg::rxEntry_t rxHead,
  input  logic             rxValid,
  output logic             rxPop,
  input  logic             sending,
  output sc_pkg::divider_t divider,
  output logic             divLoad
);

  sc_pkg::regAddr_e addr;
  logic             ack;
  logic [7:0]       rdData;
  logic             access;   // New access this cycle.
  logic             canDone;  // Addressed action completes this cycle.
  logic             isData;
  logic [7:0]       status;

  assign addr   = sc_pkg::regAddr_e'(wbReq.adr);
  assign access = wbReq.cyc && wbReq.stb && !ack; // No re-take under ack.
  assign isData = (addr == sc_pkg::DATA);

  // A write to DATA stalls while the TX queue is full.
  assign canDone = !(isData && wbReq.we) || txPushReady;

  // ******************************
  // Queue strobes
  // ******************************

  assign txPushData  = wbReq.dat;
  assign txPushValid = access && wbReq.we && isData;
  assign rxPop       = access && !wbReq.we && isData && rxValid; // Empty read pops nothing.

  // Bit3 is gated so a stale head never shows.
  assign status = {4'b0000, rxHead.parityErr && rxValid, rxValid, !txPushReady, sending};

  always_ff @(posedge CLK_I)
  begin
    if (RST_I)
    begin
      ack     <= 1'b0;
      divLoad <= 1'b0;
      divider <= `SC_DIV_W'(`SC_DIV_RESET);
    end
    else
    begin
      ack     <= access && canDone;
      divLoad <= 1'b0;
      if (access && wbReq.we && addr == sc_pkg::DIVIDER)
      begin
        divider <= wbReq.dat[`SC_DIV_W-1:0];
        divLoad <= 1'b1; // Baud counter restarts on the new value.
      end
    end
  end

  // Read data, captured with the access.
  always_ff @(posedge CLK_I)
  begin
    case (addr)
      sc_pkg::DATA:    rdData <= rxValid ? rxHead.data : 8'h00;
      sc_pkg::STATUS:  rdData <= status;
      sc_pkg::DIVIDER: rdData <= 8'(divider);
      default:         rdData <= 8'h00;
    endcase
  end

  assign wbRsp.ack = ack;
  assign wbRsp.dat = rdData;

endmodule

`default_nettype wire

// File: hdl/sc_top.sv
// Smartcard character interface top level.
// Register block, TX and RX queues, baud generator and shifters.

`default_nettype none

`include "sc_defs.svh"

module sc_top (
  input  logic           CLK_I,
  input  logic           RST_I,
  input  sc_pkg::wbReq_t wbReq,
  output sc_pkg::wbRsp_t wbRsp,
  input  logic           scIoIn,  // Wired-AND of our drive and the card's.
  output logic           scIoOut  // 1 releases, 0 pulls low.
);

  logic [7:0]       txPushData;
  logic             txPushValid;
  logic             txPushReady;
  logic [7:0]       txData;
  logic             txValid;
  logic             txReady;
  sc_pkg::rxEntry_t rxEntry;
  logic             rxEntryValid;
  sc_pkg::rxEntry_t rxHead;
  logic             rxValid;
  logic             rxPop;
  logic             sending;
  sc_pkg::divider_t divider;
  logic             divLoad;
  logic             tick;

  // ******************************
  // Host side
  // ******************************

  sc_wb_regs regs0 (
    .CLK_I, .RST_I, .wbReq, .wbRsp,
    .txPushData, .txPushValid, .txPushReady,
    .rxHead, .rxValid, .rxPop,
    .sending, .divider, .divLoad
  );

  sc_fifo #(.payload_t(logic [7:0]), .DEPTH(`SC_FIFO_DEPTH)) txFifo0 (
    .CLK_I, .RST_I,
    .pushData(txPushData), .pushValid(txPushValid), .pushReady(txPushReady),
    .popData(txData), .popValid(txValid), .popReady(txReady)
  );

  // Full queue drops the entry.
  sc_fifo #(.payload_t(sc_pkg::rxEntry_t), .DEPTH(`SC_FIFO_DEPTH)) rxFifo0 (
    .CLK_I, .RST_I,
    .pushData(rxEntry), .pushValid(rxEntryValid), .pushReady(),
    .popData(rxHead), .popValid(rxValid), .popReady(rxPop)
  );

  // ******************************
  // Card side
  // ******************************

  sc_baud_gen baud0 (.CLK_I, .RST_I, .divider, .divLoad, .tick);

  sc_out_shifter outShift0 (
    .CLK_I, .RST_I, .txData, .txValid, .txReady,
    .tick, .scIo(scIoOut), .sending
  );

  sc_in_shifter inShift0 (
    .CLK_I, .RST_I, .scIo(scIoIn), .enable(!sending), .divider,
    .rxEntry, .rxValid(rxEntryValid)
  );

endmodule

`default_nettype wire

// File: bench/sc_properties.sv
// Concurrent checks on the host bus and card line of sc_top.

`default_nettype none

module sc_properties (
  input logic           CLK_I,
  input logic           RST_I,
  input sc_pkg::wbReq_t wbReq,
  input sc_pkg::wbRsp_t wbRsp,
  input logic           scIoOut,
  input logic           sending,     // Transmitter frame in progress.
  input logic           txPushReady  // Low while the transmit queue is full.
);

  int failCount = 0; // Failed assertion count, read by the testbench.

  // ******************************
  // Host bus
  // ******************************

  // Ack is a one-cycle pulse.
  ackPulse: assert property (@(posedge CLK_I) disable iff (RST_I)
    wbRsp.ack |=> !wbRsp.ack)
    else
    begin
      failCount++;
      $error("Acknowledge stayed high for two cycles");
    end

  // A DATA write offered to a full queue must not complete.
  fullStall: assert property (@(posedge CLK_I) disable iff (RST_I)
    (wbReq.cyc && wbReq.stb && wbReq.we && wbReq.adr == 2'd0 && !wbRsp.ack
      && !txPushReady) |=> !wbRsp.ack)
    else
    begin
      failCount++;
      $error("DATA write acknowledged while the transmit queue was full");
    end

  // Card line.
  lineIdle: assert property (@(posedge CLK_I) disable iff (RST_I)
    !sending |-> scIoOut)
    else
    begin
      failCount++;
      $error("Card line driven low while the transmitter was idle");
    end

endmodule

`default_nettype wire

// File: bench/sc_tb.sv
// Testbench for sc_top: clock, reset, LFSR stimulus, Wishbone tasks,
// card model for both directions and the checking model.

`default_nettype none

`include "sc_defs.svh"

module sc_tb;

  localparam int BUS_LIMIT  = 4000; // Clocks before a bus access is abandoned.
  localparam int LINE_LIMIT = 4000; // Clocks to wait for a start bit or idle line.

  logic           CLK_I;
  logic           RST_I;
  sc_pkg::wbReq_t wbReq;
  sc_pkg::wbRsp_t wbRsp;
  logic           scIoOut;
  logic           scIoIn;
  logic           cardDrive;                 // 0 when the card pulls the line low.
  logic [31:0]    lfsrState = 32'haa19_ae82;
  int             etu = `SC_DIV_RESET + 1;   // Clocks per bit in the model.
  int             checkCount;
  int             errorCount;
  int             timeoutCount;
  int             i;
  int             j;
  logic [7:0]     rd;
  logic [7:0]     r;
  logic [7:0]     burst [`SC_FIFO_DEPTH + 2];

  assign scIoIn = scIoOut & cardDrive; // Open-drain wired-AND.

  sc_top dut0 (.CLK_I, .RST_I, .wbReq, .wbRsp, .scIoIn, .scIoOut);

  bind sc_top sc_properties props0 (
    .CLK_I(CLK_I), .RST_I(RST_I), .wbReq(wbReq), .wbRsp(wbRsp),
    .scIoOut(scIoOut), .sending(sending), .txPushReady(txPushReady)
  );

  initial
  begin
    CLK_I = 1'b0;
    forever #20 CLK_I = ~CLK_I;
  end

  // ******************************
  // Random source and checking
  // ******************************

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    // Galois form, taps 32, 22, 2, 1.
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic getRandom(input int nBits, output logic [7:0] value);
    value = '0;
    for (int k = 0; k < nBits; k++)
    begin
      lfsrState = lfsrNext(lfsrState); // One step per bit taken.
      value     = {value[6:0], lfsrState[0]};
    end
  endtask

  task automatic checkEq(input logic [7:0] got, input logic [7:0] exp, input string what);
    checkCount++;
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("FAIL %0t: %s, got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // ******************************
  // Host bus
  // ******************************

  task automatic busAccess(input logic isWrite, input logic [1:0] addr,
                           input logic [7:0] wdat, output logic [7:0] rdat);
    int waited;
    waited = 0;
    rdat   = 8'h00;
    @(negedge CLK_I);
    wbReq = '{cyc: 1'b1, stb: 1'b1, we: isWrite, adr: addr, dat: wdat};
    @(negedge CLK_I);
    while (!wbRsp.ack && waited < BUS_LIMIT)
    begin
      @(negedge CLK_I);
      waited++;
    end
    if (wbRsp.ack)
      rdat = wbRsp.dat; // Read data is valid with ack.
    else
    begin
      timeoutCount++;
      $display("Timeout: register %0d access was never acknowledged", addr);
    end
    wbReq = '0; // Drop the strobe before ack can be seen again.
  endtask

  task automatic writeReg(input logic [1:0] addr, input logic [7:0] wdat);
    logic [7:0] unused;
    busAccess(1'b1, addr, wdat, unused);
  endtask

  task automatic readReg(input logic [1:0] addr, output logic [7:0] rdat);
    busAccess(1'b0, addr, 8'h00, rdat);
  endtask

  // Polls STATUS until the transmitter has finished its frame.
  task automatic waitTxIdle();
    logic [7:0] st;
    int         tries;
    tries = 0;
    readReg(sc_pkg::STATUS, st);
    while (st[0] && tries < LINE_LIMIT)
    begin
      readReg(sc_pkg::STATUS, st);
      tries++;
    end
    if (st[0])
    begin
      timeoutCount++;
      $display("Timeout: transmitter stayed busy");
    end
  endtask

  // ******************************
  // Card model
  // ******************************

  // Samples one transmitted character at mid-bit and checks its framing.
  task automatic expectTxChar(input logic [7:0] exp);
    logic [11:0] bits;
    int          waited;
    waited = 0;
    @(negedge CLK_I);
    while (scIoOut !== 1'b0 && waited < LINE_LIMIT)
    begin
      @(negedge CLK_I);
      waited++;
    end
    if (scIoOut !== 1'b0)
    begin
      timeoutCount++;
      $display("Timeout: no start bit seen for byte %02h", exp);
    end
    else
    begin
      repeat (etu / 2) @(negedge CLK_I); // Middle of the start bit.
      for (int k = 0; k < 12; k++)
      begin
        bits[k] = scIoOut;
        if (k < 11)
          repeat (etu) @(negedge CLK_I);
      end
      checkEq({7'd0, bits[0]}, 8'h00, "start bit level");
      checkEq(bits[8:1], exp, "transmitted byte");
      checkEq({7'd0, bits[9]}, {7'd0, ^exp}, "transmitted parity");
      checkEq({6'd0, bits[11:10]}, 8'h03, "guard time released");
    end
  endtask

  // Card drives one character; parity is inverted on request.
  task automatic sendChar(input logic [7:0] data, input logic badParity);
    logic [9:0] frame;
    frame = {(^data) ^ badParity, data, 1'b0};
    for (int k = 0; k < 10; k++)
    begin
      cardDrive = frame[k];
      repeat (etu) @(negedge CLK_I);
    end
    cardDrive = 1'b1;
    repeat (2 * etu) @(negedge CLK_I); // Stop and guard time.
  endtask

  task automatic txRound(input int n);
    logic [7:0] b;
    for (int k = 0; k < n; k++)
    begin
      getRandom(8, b);
      writeReg(sc_pkg::DATA, b);
      expectTxChar(b);
    end
    waitTxIdle();
  endtask

  task automatic rxRound(input int n);
    logic [7:0] bytes [`SC_FIFO_DEPTH];
    logic       bad   [`SC_FIFO_DEPTH];
    logic [7:0] b;
    logic [7:0] st;
    logic [7:0] got;
    for (int k = 0; k < n; k++)
    begin
      getRandom(8, bytes[k]);
      getRandom(1, b);
      bad[k] = b[0] || (k == 1); // At least one bad parity per round.
      sendChar(bytes[k], bad[k]);
    end
    for (int k = 0; k < n; k++)
    begin
      readReg(sc_pkg::STATUS, st);
      checkEq({7'd0, st[2]}, 8'h01, "receive entry available");
      checkEq({7'd0, st[3]}, {7'd0, bad[k]}, "head parity flag");
      readReg(sc_pkg::DATA, got);
      checkEq(got, bytes[k], "received byte");
    end
    readReg(sc_pkg::STATUS, st);
    checkEq({7'd0, st[2]}, 8'h00, "receive queue drained");
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial
  begin
    RST_I     = 1'b1;
    wbReq     = '0;
    cardDrive = 1'b1;
    repeat (10) @(negedge CLK_I);
    RST_I = 1'b0;

    // Idle and reset state.
    checkEq({7'd0, scIoOut}, 8'h01, "line released after reset");
    readReg(sc_pkg::STATUS, rd);
    checkEq(rd, 8'h00, "STATUS after reset");
    readReg(sc_pkg::DIVIDER, rd);
    checkEq(rd, 8'(`SC_DIV_RESET), "DIVIDER after reset");
    readReg(sc_pkg::DATA, rd);
    checkEq(rd, 8'h00, "DATA read on empty queue");

    txRound(4); // Framing of single bytes.

    // Burst past the queue depth; late writes stall until space frees.
    for (i = 0; i < `SC_FIFO_DEPTH + 2; i++)
      getRandom(8, burst[i]);
    fork
      begin
        for (i = 0; i < `SC_FIFO_DEPTH + 1; i++)
          writeReg(sc_pkg::DATA, burst[i]);
        readReg(sc_pkg::STATUS, rd);
        checkEq({7'd0, rd[1]}, 8'h01, "STATUS full during burst");
        checkEq({7'd0, rd[0]}, 8'h01, "STATUS sending during burst");
        writeReg(sc_pkg::DATA, burst[`SC_FIFO_DEPTH + 1]);
      end
      begin
        for (j = 0; j < `SC_FIFO_DEPTH + 2; j++)
          expectTxChar(burst[j]); // Line order equals write order.
      end
    join
    waitTxIdle();

    rxRound(`SC_FIFO_DEPTH);

    // New bit rate between 4 and 16 clocks per etu.
    getRandom(4, r);
    r = 8'd3 + (r % 8'd13);
    writeReg(sc_pkg::DIVIDER, r);
    readReg(sc_pkg::DIVIDER, rd);
    checkEq(rd, r, "DIVIDER read back");
    etu = r + 1;
    txRound(2);
    rxRound(2);

    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checkCount, errorCount, timeoutCount, dut0.props0.failCount);
    if (errorCount == 0 && timeoutCount == 0 && dut0.props0.failCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
hdl/sc_pkg.sv
hdl/sc_baud_gen.sv
hdl/sc_fifo.sv
hdl/sc_out_shifter.sv
hdl/sc_in_shifter.sv
hdl/sc_wb_regs.sv
hdl/sc_top.sv
bench/sc_properties.sv
bench/sc_tb.sv

// File: Bender.yml
package:
  name: sc_iface

export_include_dirs:
  - include

sources:
  - files:
      - hdl/sc_pkg.sv
      - hdl/sc_baud_gen.sv
      - hdl/sc_fifo.sv
      - hdl/sc_out_shifter.sv
      - hdl/sc_in_shifter.sv
      - hdl/sc_wb_regs.sv
      - hdl/sc_top.sv
  - target: test
    files:
      - bench/sc_properties.sv
      - bench/sc_tb.sv
